// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --timescale 1ns/100ps
TOP       := chirp_lane_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/chirp_lane_model.svh ====
// testbench copy of the lane state
logic [chirp_pkg::SAMPLE_W-1:0] mdl_weight [NUM];
chirp_pkg::mode_e               mdl_mode;
int                             mdl_idx;
int                             mdl_drain;

// expected results with the cycle each one is due
chirp_pkg::sample_t             exp_q [$];
int                             due_q [$];

// sign of the full product over its low 15 bits
function automatic logic [15:0] narrow_lane(longint full);
  logic [15:0] n;
  n[15]   = (full < 0);
  n[14:0] = full[14:0];
  return n;
endfunction

// plain four multiplier complex product
function automatic chirp_pkg::sample_t complex_product(chirp_pkg::sample_t x,
                                                       chirp_pkg::sample_t w);
  longint             re_full;
  longint             im_full;
  chirp_pkg::sample_t y;
  re_full = longint'($signed(x.cpx.re)) * longint'($signed(w.cpx.re))
          - longint'($signed(x.cpx.im)) * longint'($signed(w.cpx.im));
  im_full = longint'($signed(x.cpx.re)) * longint'($signed(w.cpx.im))
          + longint'($signed(x.cpx.im)) * longint'($signed(w.cpx.re));
  y.cpx.re = narrow_lane(re_full);
  y.cpx.im = narrow_lane(im_full);
  return y;
endfunction

// two unrelated lane products
function automatic chirp_pkg::sample_t real_product(chirp_pkg::sample_t x,
                                                    chirp_pkg::sample_t w);
  chirp_pkg::sample_t y;
  y.pair.hi = narrow_lane(longint'($signed(x.pair.hi)) * longint'($signed(w.pair.hi)));
  y.pair.lo = narrow_lane(longint'($signed(x.pair.lo)) * longint'($signed(w.pair.lo)));
  return y;
endfunction

// what a bus read of adr should return
function automatic logic [31:0] expected_read(int adr);
  if (adr < NUM) begin
    return mdl_weight[adr];
  end
  if (adr == NUM) begin
    return 32'(mdl_mode);
  end
  return 32'h0;
endfunction

// one clock edge of the lane
// the sample taken on this edge still sees the old weight, mode and index
task automatic model_edge(int cyc, logic acc, chirp_pkg::sample_t x,
                          logic wr, int adr, logic [31:0] dat);
  chirp_pkg::sample_t w;
  chirp_pkg::mode_e   new_mode;
  logic               change;
  if (acc) begin
    w = chirp_pkg::sample_t'(mdl_weight[mdl_idx]);
    if (mdl_mode == chirp_pkg::MODE_COMPLEX) begin
      exp_q.push_back(complex_product(x, w));
      // the accepting edge is the first latency cycle
      due_q.push_back(cyc + chirp_pkg::MUL_COMPLEX_LAT - 1);
    end else begin
      exp_q.push_back(real_product(x, w));
      due_q.push_back(cyc + chirp_pkg::MUL_REAL_LAT - 1);
    end
    mdl_idx = (mdl_idx + 1) % NUM;
  end
  new_mode = chirp_pkg::mode_e'(dat[chirp_pkg::CTRL_MODE_BIT]);
  change   = wr && (adr == NUM) && (new_mode != mdl_mode);
  if (wr && (adr < NUM)) begin
    mdl_weight[adr] = dat;
  end
  if (wr && (adr == NUM)) begin
    mdl_mode = new_mode;
    mdl_idx  = 0;
  end
  // input held off for a full complex latency after a mode change
  if (change) begin
    mdl_drain = chirp_pkg::MUL_COMPLEX_LAT;
  end else if (mdl_drain > 0) begin
    mdl_drain--;
  end
endtask

// ==== bench/chirp_lane_tb.sv ====
`timescale 1ns/100ps

module chirp_lane_tb;

  localparam int NUM         = 8;
  localparam int ADR_W       = $clog2(NUM + 1);
  localparam int SAMPLES     = 200;
  localparam int IDX_SAMPLES = 20;
  localparam int MAX_GAP     = 3;
  localparam int FLUSH_IDLE  = 8;
  localparam int BUS_OPS     = 64;
  // streams, bus accesses, flushes and drains with headroom
  localparam int CYCLE_LIMIT = 5 + (2 * SAMPLES + 2 * IDX_SAMPLES) * (MAX_GAP + 1)
                             + 2 * BUS_OPS
                             + 8 * (chirp_pkg::MUL_COMPLEX_LAT + FLUSH_IDLE) + 500;

  logic        clk;
  logic        rst_n;
  logic        i_wb_cyc;
  logic        i_wb_stb;
  logic        i_wb_we;
  logic [ADR_W-1:0] i_wb_adr;
  logic [31:0] i_wb_dat;
  logic [31:0] o_wb_dat;
  logic        o_wb_ack;
  logic        i_x_valid;
  logic [31:0] i_x_data;
  logic        o_x_ready;
  logic        o_y_valid;
  logic [31:0] o_y_data;

  int          cycle;
  int          ack_cycle;
  logic        last_accept;
  logic        stream_on;
  string       test_name;

  `include "chirp_lane_model.svh"

  chirp_lane_top #(.NUM(NUM)) dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_wb_cyc  (i_wb_cyc),
    .i_wb_stb  (i_wb_stb),
    .i_wb_we   (i_wb_we),
    .i_wb_adr  (i_wb_adr),
    .i_wb_dat  (i_wb_dat),
    .o_wb_dat  (o_wb_dat),
    .o_wb_ack  (o_wb_ack),
    .i_x_valid (i_x_valid),
    .i_x_data  (i_x_data),
    .o_x_ready (o_x_ready),
    .o_y_valid (o_y_valid),
    .o_y_data  (o_y_data)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // error handling and compares
  //////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display(">>> FAIL");
    $fatal(1, "run stopped at cycle %0d", cycle);
  endtask

  task automatic report_error(string msg);
    $display("ERROR in %s at cycle %0d: %s", test_name, cycle, msg);
    stop_run();
  endtask

  task automatic check_result(string name, chirp_pkg::sample_t exp, chirp_pkg::sample_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_rdata(string name, logic [31:0] exp, logic [31:0] act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("FAILED %s: expected %b actual %b", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (act != exp) begin
      $display("FAILED %s: expected %0d actual %0d", name, exp, act);
      stop_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////

  // corners push the narrowing through its sign and wrap cases
  function automatic logic [15:0] random_lane(logic extreme);
    logic [15:0] corner [5];
    corner = '{16'h8000, 16'h7fff, 16'hffff, 16'h0000, 16'h0001};
    if (extreme && ($urandom_range(1, 0) == 1)) begin
      return corner[$urandom_range(4, 0)];
    end
    return 16'($urandom);
  endfunction

  function automatic logic [31:0] random_word(logic extreme);
    return {random_lane(extreme), random_lane(extreme)};
  endfunction

  // scoreboard side of every cycle
  task automatic check_outputs();
    check_flag({test_name, " ready"}, (mdl_drain == 0), o_x_ready);
    if (o_y_valid) begin
      if (due_q.size() == 0) begin
        report_error("output valid while no result was expected");
      end else if (due_q[0] != cycle) begin
        report_error($sformatf("result came at cycle %0d but was due at %0d",
                               cycle, due_q[0]));
      end else begin
        void'(due_q.pop_front());
        check_result(test_name, exp_q.pop_front(), chirp_pkg::sample_t'(o_y_data));
      end
    end else if ((due_q.size() > 0) && (due_q[0] <= cycle)) begin
      report_error("an expected result never appeared on the output");
    end
  endtask

  // inputs seen before the edge and outputs checked after it
  task automatic step();
    logic acc;
    logic wr;
    int   adr;
    logic [31:0] dat;
    chirp_pkg::sample_t x;
    acc = i_x_valid && o_x_ready;
    wr  = i_wb_cyc && i_wb_stb && i_wb_we;
    adr = int'(i_wb_adr);
    dat = i_wb_dat;
    x   = chirp_pkg::sample_t'(i_x_data);
    @(posedge clk);
    cycle++;
    if (cycle > CYCLE_LIMIT) begin
      report_error("cycle limit reached before the tests finished");
    end else begin
      model_edge(cycle, acc, x, wr, adr, dat);
      last_accept = acc;
      #2;
      check_outputs();
      if (stream_on && acc) begin
        i_x_data = random_word(1'b0);
      end
    end
  endtask

  // classic cycle with ack due on the first edge for one cycle
  task automatic bus_access(logic we, int adr, logic [31:0] dat);
    int waited;
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = we;
    i_wb_adr = ADR_W'(adr);
    i_wb_dat = dat;
    waited   = 0;
    do begin
      step();
      waited++;
    end while (!o_wb_ack);
    check_count({test_name, " ack delay"}, 1, waited);
    if (!we) begin
      check_rdata($sformatf("%s read %0d", test_name, adr), expected_read(adr), o_wb_dat);
    end
    ack_cycle = cycle;
    i_wb_cyc  = 1'b0;
    i_wb_stb  = 1'b0;
    i_wb_we   = 1'b0;
    step();
    check_flag({test_name, " ack width"}, 1'b0, o_wb_ack);
  endtask

  task automatic measure_drain();
    while (!o_x_ready) begin
      step();
    end
    check_count({test_name, " drain"}, chirp_pkg::MUL_COMPLEX_LAT, cycle - ack_cycle);
  endtask

  // n samples with short random gaps
  task automatic stream_samples(int n, logic extreme);
    int gap;
    stream_on = 1'b0;
    for (int k = 0; k < n; k++) begin
      gap       = $urandom_range(MAX_GAP, 0);
      i_x_valid = 1'b0;
      repeat (gap) step();
      i_x_valid = 1'b1;
      i_x_data  = random_word(extreme);
      do begin
        step();
      end while (!last_accept);
    end
    i_x_valid = 1'b0;
  endtask

  task automatic flush();
    i_x_valid = 1'b0;
    stream_on = 1'b0;
    while (due_q.size() > 0) begin
      step();
    end
    repeat (FLUSH_IDLE) step();
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n       = 1'b0;
    i_wb_cyc    = 1'b0;
    i_wb_stb    = 1'b0;
    i_wb_we     = 1'b0;
    i_wb_adr    = '0;
    i_wb_dat    = '0;
    i_x_valid   = 1'b0;
    i_x_data    = '0;
    cycle       = 0;
    ack_cycle   = 0;
    last_accept = 1'b0;
    stream_on   = 1'b0;
    test_name   = "reset";
    mdl_mode    = chirp_pkg::MODE_COMPLEX;
    mdl_idx     = 0;
    mdl_drain   = 0;
    for (int i = 0; i < NUM; i++) begin
      mdl_weight[i] = '0;
    end
    void'($urandom(32'h6c18c751));

    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;

    check_flag("reset y_valid", 1'b0, o_y_valid);
    check_flag("reset wb_ack", 1'b0, o_wb_ack);
    check_flag("reset x_ready", 1'b1, o_x_ready);
    for (int a = 0; a <= NUM; a++) begin
      bus_access(1'b0, a, '0);
    end

    // weights, control and unmapped space
    test_name = "register access";
    for (int a = 0; a < NUM; a++) begin
      bus_access(1'b1, a, $urandom);
    end
    for (int a = 0; a < NUM; a++) begin
      bus_access(1'b0, a, '0);
    end
    bus_access(1'b1, NUM, $urandom & 32'hffff_fffe);
    bus_access(1'b0, NUM, '0);
    bus_access(1'b1, NUM + 1, $urandom);
    for (int a = NUM + 1; a < (1 << ADR_W); a++) begin
      bus_access(1'b0, a, '0);
    end

    test_name = "complex mode";
    stream_samples(SAMPLES, 1'b0);
    flush();

    // corner weights too so both operands reach the extremes
    test_name = "real mode";
    for (int a = 0; a < NUM; a++) begin
      bus_access(1'b1, a, random_word(1'b1));
    end
    bus_access(1'b1, NUM, $urandom | 32'h1);
    measure_drain();
    // control reads back the mode bit alone
    bus_access(1'b0, NUM, '0);
    stream_samples(SAMPLES, 1'b1);
    flush();

    // mode changes while the input never stops offering samples
    test_name = "mode drain";
    i_x_valid = 1'b1;
    i_x_data  = random_word(1'b0);
    stream_on = 1'b1;
    repeat (6) step();
    bus_access(1'b1, NUM, 32'h0);
    measure_drain();
    repeat (6) step();
    bus_access(1'b1, NUM, 32'h0);
    repeat (4) begin
      check_flag({test_name, " same mode ready"}, 1'b1, o_x_ready);
      step();
    end
    bus_access(1'b1, NUM, 32'h1);
    measure_drain();
    repeat (6) step();
    flush();

    // control write in the middle restarts at weight 0
    test_name = "index reset";
    stream_samples(IDX_SAMPLES, 1'b0);
    i_x_valid = 1'b1;
    i_x_data  = random_word(1'b0);
    stream_on = 1'b1;
    repeat (3) step();
    bus_access(1'b1, NUM, 32'h1);
    repeat (5) step();
    stream_samples(IDX_SAMPLES, 1'b0);
    flush();

    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== logic/chirp_lane_top.sv ====
`timescale 1ns/100ps

// one chirp processing lane
// weight bank feeding the dual mode multiplier
module chirp_lane_top #(
  parameter  int NUM   = 8,
  localparam int ADR_W = $clog2(NUM + 1)
) (
  input  logic                          clk,
  input  logic                          rst_n,
  // wishbone classic slave
  input  logic                          i_wb_cyc,
  input  logic                          i_wb_stb,
  input  logic                          i_wb_we,
  input  logic [ADR_W-1:0]              i_wb_adr,
  input  logic [chirp_pkg::SAMPLE_W-1:0] i_wb_dat,
  output logic [chirp_pkg::SAMPLE_W-1:0] o_wb_dat,
  output logic                          o_wb_ack,
  // sample stream in
  input  logic                          i_x_valid,
  input  logic [chirp_pkg::SAMPLE_W-1:0] i_x_data,
  output logic                          o_x_ready,
  // result stream out
  output logic                          o_y_valid,
  output logic [chirp_pkg::SAMPLE_W-1:0] o_y_data
);

  // bank to multiplier link
  chirp_sample_if smp ();

  // result word before it leaves as plain bits
  chirp_pkg::sample_t y_word;

  weight_bank #(
    .NUM (NUM)
  ) u_bank (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_wb_cyc  (i_wb_cyc),
    .i_wb_stb  (i_wb_stb),
    .i_wb_we   (i_wb_we),
    .i_wb_adr  (i_wb_adr),
    .i_wb_dat  (i_wb_dat),
    .o_wb_dat  (o_wb_dat),
    .o_wb_ack  (o_wb_ack),
    .i_x_valid (i_x_valid),
    .i_x_data  (i_x_data),
    .o_x_ready (o_x_ready),
    .sout      (smp.bank)
  );

  chirp_mult u_mult (
    .clk       (clk),
    .rst_n     (rst_n),
    .sin       (smp.mult),
    .o_y_valid (o_y_valid),
    .o_y       (y_word)
  );

  assign o_y_data = y_word;

endmodule

// ==== logic/chirp_mult.sv ====
`timescale 1ns/100ps

// dual mode weight multiplier
// complex mode gives y = x * w with three multipliers
// real mode gives two independent lane products
// each 16 bit lane keeps the product sign over its low 15 bits
module chirp_mult (
  input  logic               clk,
  input  logic               rst_n,
  chirp_sample_if.mult       sin,
  output logic               o_y_valid,
  output chirp_pkg::sample_t o_y
);

  localparam int HW = chirp_pkg::HALF_W;

  // sin is already registered by the bank
  // that register is the input stage of both paths
  localparam int CPX_TAG_D  = chirp_pkg::MUL_COMPLEX_LAT - 2;
  localparam int REAL_TAG_D = chirp_pkg::MUL_REAL_LAT - 2;

  // complex path operands
  logic signed [HW:0]     re_plus_im;
  logic signed [HW:0]     wr_minus_wi;

  // complex path products
  logic signed [2*HW-1:0] p_re_wi;
  logic signed [2*HW-1:0] p_im_wr;
  logic signed [2*HW+1:0] p_sum;

  // recombination terms
  logic signed [2*HW:0]   p_diff_q;
  logic signed [2*HW:0]   im_sum;
  logic signed [2*HW:0]   im_sum_d;
  logic signed [2*HW+1:0] re_full;

  // real path products
  logic signed [2*HW-1:0] p_hi;
  logic signed [2*HW-1:0] p_lo;

  // {valid, mode} tags at both path depths
  logic [1:0]             cpx_tag;
  logic [1:0]             real_tag;
  logic                   cpx_out;
  logic                   real_out;

  //////////////////////////////////////////////////////////////////////
  // complex path
  //////////////////////////////////////////////////////////////////////

  // (re + im) and (wr - wi) for the shared product
  always_ff @(posedge clk) begin
    re_plus_im  <= $signed(sin.x.cpx.re) + $signed(sin.x.cpx.im);
    wr_minus_wi <= $signed(sin.w.cpx.re) - $signed(sin.w.cpx.im);
  end

  // cross products start straight from the bank register
  // so they finish one cycle ahead of the shared product
  signed_mult_pipe #(.A_W(HW), .B_W(HW), .STAGES(3)) u_mul_re_wi (
    .clk (clk),
    .i_a (sin.x.cpx.re),
    .i_b (sin.w.cpx.im),
    .o_p (p_re_wi)
  );

  signed_mult_pipe #(.A_W(HW), .B_W(HW), .STAGES(3)) u_mul_im_wr (
    .clk (clk),
    .i_a (sin.x.cpx.im),
    .i_b (sin.w.cpx.re),
    .o_p (p_im_wr)
  );

  // (re + im) * (wr - wi)
  signed_mult_pipe #(.A_W(HW+1), .B_W(HW+1), .STAGES(3)) u_mul_sum (
    .clk (clk),
    .i_a (re_plus_im),
    .i_b (wr_minus_wi),
    .o_p (p_sum)
  );

  // re*wi - im*wr lands together with p_sum
  always_ff @(posedge clk) begin
    p_diff_q <= p_re_wi - p_im_wr;
  end

  // imaginary part needs one more cycle to meet the real part
  assign im_sum = p_re_wi + p_im_wr;

  pipe_delay #(.DEPTH(1), .WIDTH(2*HW+1)) u_im_delay (
    .clk   (clk),
    .rst_n (rst_n),
    .i_d   (im_sum),
    .o_q   (im_sum_d)
  );

  // re*wr - im*wi
  // true value fits 33 bits so the top bit here is the real sign
  assign re_full = p_sum + p_diff_q;

  //////////////////////////////////////////////////////////////////////
  // real path
  //////////////////////////////////////////////////////////////////////

  signed_mult_pipe #(.A_W(HW), .B_W(HW), .STAGES(1)) u_mul_hi (
    .clk (clk),
    .i_a (sin.x.pair.hi),
    .i_b (sin.w.pair.hi),
    .o_p (p_hi)
  );

  signed_mult_pipe #(.A_W(HW), .B_W(HW), .STAGES(1)) u_mul_lo (
    .clk (clk),
    .i_a (sin.x.pair.lo),
    .i_b (sin.w.pair.lo),
    .o_p (p_lo)
  );

  //////////////////////////////////////////////////////////////////////
  // tag alignment and output register
  //////////////////////////////////////////////////////////////////////

  pipe_delay #(.DEPTH(CPX_TAG_D), .WIDTH(2)) u_cpx_tag (
    .clk   (clk),
    .rst_n (rst_n),
    .i_d   ({sin.valid, sin.mode}),
    .o_q   (cpx_tag)
  );

  pipe_delay #(.DEPTH(REAL_TAG_D), .WIDTH(2)) u_real_tag (
    .clk   (clk),
    .rst_n (rst_n),
    .i_d   ({sin.valid, sin.mode}),
    .o_q   (real_tag)
  );

  // a sample leaves only at the depth its own mode names
  assign cpx_out  = cpx_tag[1] && (cpx_tag[0] == chirp_pkg::MODE_COMPLEX);
  assign real_out = real_tag[1] && (real_tag[0] == chirp_pkg::MODE_REAL);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_y_valid <= 1'b0;
    end else begin
      o_y_valid <= cpx_out || real_out;
    end
  end

  // narrowing keeps sign plus low 15 bits with no saturation
  always_ff @(posedge clk) begin
    if (real_out) begin
      o_y.pair.hi <= {p_hi[2*HW-1], p_hi[HW-2:0]};
      o_y.pair.lo <= {p_lo[2*HW-1], p_lo[HW-2:0]};
    end else if (cpx_out) begin
      o_y.cpx.im <= {im_sum_d[2*HW], im_sum_d[HW-2:0]};
      o_y.cpx.re <= {re_full[2*HW+1], re_full[HW-2:0]};
    end
  end

endmodule

// ==== logic/chirp_pkg.sv ====
package chirp_pkg;

  // word widths
  localparam int SAMPLE_W = 32;
  localparam int HALF_W   = 16;

  // end-to-end lane latency per mode
  // counted from the accepting edge at the lane input
  localparam int MUL_COMPLEX_LAT = 6;
  localparam int MUL_REAL_LAT    = 3;

  // complex view with imaginary part in the upper half
  typedef struct packed {
    logic signed [HALF_W-1:0] im;
    logic signed [HALF_W-1:0] re;
  } cpx_t;

  // real view holds two independent lanes
  typedef struct packed {
    logic signed [HALF_W-1:0] hi;
    logic signed [HALF_W-1:0] lo;
  } pair_t;

  // one sample word read either way
  typedef union packed {
    cpx_t  cpx;
    pair_t pair;
  } sample_t;

  typedef enum logic {
    MODE_COMPLEX = 1'b0,
    MODE_REAL    = 1'b1
  } mode_e;

  // control register layout
  localparam int CTRL_MODE_BIT = 0;

endpackage

// ==== logic/chirp_sample_if.sv ====
`timescale 1ns/100ps

// one sample with its weight from the bank into the multiplier
// no handshake here
// valid marks a single sample on that clock edge
interface chirp_sample_if;

  // sample strobe
  logic               valid;

  // input word as received
  chirp_pkg::sample_t x;

  // weight picked for this sample
  chirp_pkg::sample_t w;

  // mode travels with every sample
  // so both modes can be in flight at once
  chirp_pkg::mode_e   mode;

  // bank side drives everything
  modport bank (
    output valid,
    output x,
    output w,
    output mode
  );

  // multiplier side only listens
  modport mult (
    input valid,
    input x,
    input w,
    input mode
  );

endinterface

// ==== logic/pipe_delay.sv ====
`timescale 1ns/100ps

// shift line of DEPTH registers
// used to line up strobes and side data with a datapath
module pipe_delay #(
  parameter int DEPTH = 1,
  parameter int WIDTH = 1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [WIDTH-1:0] i_d,
  output logic [WIDTH-1:0] o_q
);

  // stage 0 takes the input and the last stage drives the output
  logic [WIDTH-1:0] stage_q [DEPTH];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= i_d;
      // move everything one step down the line
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign o_q = stage_q[DEPTH-1];

endmodule

// ==== logic/signed_mult_pipe.sv ====
`timescale 1ns/100ps

// signed multiply followed by STAGES register stages
// synthesis may retime the multiplier into the stages
module signed_mult_pipe #(
  parameter int A_W    = 16,
  parameter int B_W    = 16,
  parameter int STAGES = 1
) (
  input  logic                       clk,
  input  logic signed [A_W-1:0]      i_a,
  input  logic signed [B_W-1:0]      i_b,
  output logic signed [A_W+B_W-1:0]  o_p
);

  localparam int P_W = A_W + B_W;

  // full width product chain
  logic signed [P_W-1:0] prod_q [STAGES];

  // raw product
  // both operands signed so the sign carries into P_W bits
  logic signed [P_W-1:0] prod;

  assign prod = i_a * i_b;

  // product moves one stage per clock
  always_ff @(posedge clk) begin
    prod_q[0] <= prod;
    for (int s = 1; s < STAGES; s++) begin
      prod_q[s] <= prod_q[s-1];
    end
  end

  // last stage out
  assign o_p = prod_q[STAGES-1];

endmodule

// ==== logic/weight_bank.sv ====
`timescale 1ns/100ps

// wishbone classic slave holding the weights and the mode
// hands each accepted sample to the multiplier with its weight
module weight_bank #(
  parameter  int NUM   = 8,
  localparam int ADR_W = $clog2(NUM + 1)
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          i_wb_cyc,
  input  logic                          i_wb_stb,
  input  logic                          i_wb_we,
  input  logic [ADR_W-1:0]              i_wb_adr,
  input  logic [chirp_pkg::SAMPLE_W-1:0] i_wb_dat,
  output logic [chirp_pkg::SAMPLE_W-1:0] o_wb_dat,
  output logic                          o_wb_ack,
  input  logic                          i_x_valid,
  input  logic [chirp_pkg::SAMPLE_W-1:0] i_x_data,
  output logic                          o_x_ready,
  chirp_sample_if.bank                  sout
);

  localparam int IDX_W = (NUM > 1) ? $clog2(NUM) : 1;
  localparam int CNT_W = $clog2(chirp_pkg::MUL_COMPLEX_LAT + 1);

  logic [chirp_pkg::SAMPLE_W-1:0] weight_q [NUM];
  logic [chirp_pkg::SAMPLE_W-1:0] rd_data;
  logic [IDX_W-1:0]               idx_q;
  logic [CNT_W-1:0]               drain_q;
  chirp_pkg::mode_e               mode_q;
  chirp_pkg::mode_e               wr_mode;
  logic                           wb_req;
  logic                           wb_wr;
  logic                           ctrl_wr;
  logic                           accept;

  //////////////////////////////////////////////////////////////////////
  // bus side
  //////////////////////////////////////////////////////////////////////

  // request ignored in the ack cycle
  // gives the one-high one-low ack pattern
  assign wb_req  = i_wb_cyc && i_wb_stb && !o_wb_ack;
  assign wb_wr   = wb_req && i_wb_we;
  assign ctrl_wr = wb_wr && (i_wb_adr == ADR_W'(NUM));
  assign wr_mode = chirp_pkg::mode_e'(i_wb_dat[chirp_pkg::CTRL_MODE_BIT]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_wb_ack <= 1'b0;
    end else begin
      o_wb_ack <= wb_req;
    end
  end

  // weight writes land on the ack edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM; i++) begin
        weight_q[i] <= '0;
      end
    end else if (wb_wr) begin
      for (int i = 0; i < NUM; i++) begin
        if (i_wb_adr == ADR_W'(i)) begin
          weight_q[i] <= i_wb_dat;
        end
      end
    end
  end

  // read mux
  // unmapped addresses fall through as zero
  always_comb begin
    rd_data = '0;
    for (int i = 0; i < NUM; i++) begin
      if (i_wb_adr == ADR_W'(i)) begin
        rd_data = weight_q[i];
      end
    end
    if (i_wb_adr == ADR_W'(NUM)) begin
      rd_data[chirp_pkg::CTRL_MODE_BIT] = mode_q;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_req && !i_wb_we) begin
      o_wb_dat <= rd_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // mode and drain
  //////////////////////////////////////////////////////////////////////

  // a real mode change holds input off for a full complex latency
  // rewriting the same mode leaves ready alone
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mode_q  <= chirp_pkg::MODE_COMPLEX;
      drain_q <= '0;
    end else begin
      if (ctrl_wr) begin
        mode_q <= wr_mode;
      end
      if (ctrl_wr && (wr_mode != mode_q)) begin
        drain_q <= CNT_W'(chirp_pkg::MUL_COMPLEX_LAT);
      end else if (drain_q != '0) begin
        drain_q <= drain_q - 1'b1;
      end
    end
  end

  assign o_x_ready = (drain_q == '0);
  assign accept    = i_x_valid && o_x_ready;

  //////////////////////////////////////////////////////////////////////
  // sample side
  //////////////////////////////////////////////////////////////////////

  // control write restarts the sequence
  // even if a sample is taken on the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx_q <= '0;
    end else if (ctrl_wr) begin
      idx_q <= '0;
    end else if (accept) begin
      idx_q <= (idx_q == IDX_W'(NUM - 1)) ? '0 : idx_q + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sout.valid <= 1'b0;
      sout.mode  <= chirp_pkg::MODE_COMPLEX;
    end else begin
      sout.valid <= accept;
      if (accept) begin
        sout.mode <= mode_q;
      end
    end
  end

  // sample and weight payload
  always_ff @(posedge clk) begin
    if (accept) begin
      sout.x <= chirp_pkg::sample_t'(i_x_data);
      sout.w <= weight_q[idx_q];
    end
  end

endmodule

// ==== vlog.f ====
+incdir+bench
logic/chirp_pkg.sv
logic/chirp_sample_if.sv
logic/pipe_delay.sv
logic/signed_mult_pipe.sv
logic/chirp_mult.sv
logic/weight_bank.sv
logic/chirp_lane_top.sv
bench/chirp_lane_tb.sv
